/* logic/gemac_rx_pkg.sv */
package gemac_rx_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [47:0] mac_addr_t;
   typedef logic [10:0] byte_idx_t;    // bytes since the sfd, saturating.
   typedef logic [15:0] quanta_t;

   typedef enum logic [3:0] {
      RX_IDLE, RX_PREAMBLE, RX_FRAME, RX_GOODFRAME, RX_DO_PAUSE, RX_ERROR, RX_DROP,
      RX_PAUSE_SKIP, RX_PAUSE_CHK88, RX_PAUSE_CHK08, RX_PAUSE_CHK00, RX_PAUSE_CHK01,
      RX_PAUSE_STORE_MSB, RX_PAUSE_STORE_LSB, RX_PAUSE_WAIT_CRC
   } rx_state_e;

   localparam byte_t       PREAMBLE_BYTE = 8'h55;
   localparam byte_t       SFD_BYTE      = 8'hD5;

   localparam mac_addr_t   BCAST_ADDR    = 48'hFFFF_FFFF_FFFF;
   localparam mac_addr_t   PAUSE_ADDR    = 48'h0180_C200_0001;

   // mac control type 8808, opcode 0001.
   localparam byte_t       PAUSE_TYPE_HI = 8'h88;
   localparam byte_t       PAUSE_TYPE_LO = 8'h08;
   localparam byte_t       PAUSE_OP_HI   = 8'h00;
   localparam byte_t       PAUSE_OP_LO   = 8'h01;

   localparam byte_idx_t   ADDR_LAST_IDX = 11'd5;    // last destination byte.
   localparam byte_idx_t   TYPE_IDX      = 11'd12;   // first length/type byte.

   localparam logic [31:0] CRC_RESIDUE   = 32'hC704_DD7B;

endpackage

/* logic/rx_delay_line.sv */
`timescale 1ns/1ps

module rx_delay_line
  #(
   parameter int DELAY_DEPTH = 6
  )
  (
   input  logic                rx_clk,
   input  logic                reset,
   input  gemac_rx_pkg::byte_t din_data,
   input  logic                din_dv,
   input  logic                din_er,
   output gemac_rx_pkg::byte_t dout_data,
   output logic                dout_dv,
   output logic                dout_er
  );

   gemac_rx_pkg::byte_t    data_q [DELAY_DEPTH];
   logic [DELAY_DEPTH-1:0] dv_q;
   logic [DELAY_DEPTH-1:0] er_q;

   always_ff @(posedge rx_clk)
   begin
      data_q[0] <= din_data;
      for (int i = 1; i < DELAY_DEPTH; i++)
         data_q[i] <= data_q[i-1];
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         dv_q <= '0;
         er_q <= '0;
      end
      else
      begin
         dv_q[0] <= din_dv;
         er_q[0] <= din_er;
         for (int i = 1; i < DELAY_DEPTH; i++)
         begin
            dv_q[i] <= dv_q[i-1];
            er_q[i] <= er_q[i-1];
         end
      end
   end

   assign dout_data = data_q[DELAY_DEPTH-1];
   assign dout_dv   = dv_q[DELAY_DEPTH-1];
   assign dout_er   = er_q[DELAY_DEPTH-1];

endmodule

/* logic/rx_byte_counter.sv */
`timescale 1ns/1ps

module rx_byte_counter
  (
   input  logic                    rx_clk,
   input  logic                    reset,
   input  logic                    clear,
   input  logic                    count_en,
   output gemac_rx_pkg::byte_idx_t byte_idx
  );

   logic at_max;

   assign at_max = (byte_idx == '1);

   // sticks at the top so a giant frame never wraps back into the address bytes.
   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         byte_idx <= '0;
      end
      else if (clear)
      begin
         byte_idx <= '0;
      end
      else if (count_en && !at_max)
      begin
         byte_idx <= byte_idx + 1'b1;
      end
   end

endmodule

/* logic/address_filter.sv */
`timescale 1ns/1ps

module address_filter
  (
   input  logic                    rx_clk,
   input  logic                    reset,
   input  logic                    start,
   input  gemac_rx_pkg::byte_t     data,
   input  gemac_rx_pkg::byte_idx_t byte_idx,
   input  gemac_rx_pkg::mac_addr_t address,
   output logic                    match,
   output logic                    done
  );

   gemac_rx_pkg::byte_t addr_byte;
   logic                armed;
   logic                hit;

   // wire order is msb byte first.
   always_comb
   begin
      case (byte_idx)
         11'd0:   addr_byte = address[47:40];
         11'd1:   addr_byte = address[39:32];
         11'd2:   addr_byte = address[31:24];
         11'd3:   addr_byte = address[23:16];
         11'd4:   addr_byte = address[15:8];
         default: addr_byte = address[7:0];
      endcase
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         armed <= 1'b0;
         hit   <= 1'b0;
         match <= 1'b0;
         done  <= 1'b0;
      end
      else if (start)
      begin
         armed <= 1'b1;
         hit   <= 1'b1;
         match <= 1'b0;
         done  <= 1'b0;
      end
      else if (armed)
      begin
         if (byte_idx == gemac_rx_pkg::ADDR_LAST_IDX)
         begin
            armed <= 1'b0;
            done  <= 1'b1;                         // visible at index 6.
            match <= hit && (data == addr_byte);
         end
         else if (data != addr_byte)
            hit <= 1'b0;
      end
   end

endmodule

/* logic/crc32_check.sv */
`timescale 1ns/1ps

module crc32_check
  (
   input  logic                rx_clk,
   input  logic                reset,
   input  logic                clear,
   input  logic                calc,
   input  gemac_rx_pkg::byte_t data,
   output logic                crc_match
  );

   localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;

   logic [31:0] crc_q;
   logic [31:0] crc_next;

   // bits go in lsb first, as they are sent on the wire.
   always_comb
   begin
      crc_next = crc_q;
      for (int i = 0; i < 8; i++)
      begin
         if (crc_next[31] ^ data[i])
            crc_next = {crc_next[30:0], 1'b0} ^ CRC_POLY;
         else
            crc_next = {crc_next[30:0], 1'b0};
      end
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset || clear)
      begin
         crc_q <= '1;
      end
      else if (calc)
      begin
         crc_q <= crc_next;
      end
   end

   // the fcs folded into the register leaves a fixed residue.
   assign crc_match = (crc_q == gemac_rx_pkg::CRC_RESIDUE);

endmodule

/* logic/rx_frame_fsm.sv */
`timescale 1ns/1ps

module rx_frame_fsm
  #(
   parameter int MIN_PAUSE_LEN = 64
  )
  (
   input  logic                    rx_clk,
   input  logic                    reset,
   input  gemac_rx_pkg::byte_t     rxd,
   input  logic                    rx_dv,
   input  logic                    rx_er,
   input  gemac_rx_pkg::byte_idx_t byte_idx,
   input  logic                    is_ucast,
   input  logic                    is_mcast,
   input  logic                    is_bcast,
   input  logic                    is_pause,
   input  logic                    filt_done,
   input  logic                    pass_ucast,
   input  logic                    pass_mcast,
   input  logic                    pass_bcast,
   input  logic                    pass_pause,
   input  logic                    pass_all,
   input  logic                    crc_match,
   output logic                    sfd_seen,
   output logic                    crc_clear,
   output logic                    crc_calc,
   output logic                    rx_valid,
   output logic                    rx_ack,
   output logic                    rx_error,
   output gemac_rx_pkg::quanta_t   pause_quanta,
   output logic                    pause_rcvd
  );

   gemac_rx_pkg::rx_state_e state;
   gemac_rx_pkg::rx_state_e state_next;
   gemac_rx_pkg::quanta_t   quanta_hold;
   gemac_rx_pkg::byte_idx_t out_idx;
   logic                    keep;
   logic                    long_enough;

   assign long_enough = (byte_idx >= MIN_PAUSE_LEN);

   always_comb
   begin
      state_next = state;
      if (rx_er)
         state_next = gemac_rx_pkg::RX_ERROR;
      else
      begin
         case (state)
            gemac_rx_pkg::RX_IDLE:
               if (rx_dv && rxd == gemac_rx_pkg::PREAMBLE_BYTE)
                  state_next = gemac_rx_pkg::RX_PREAMBLE;
               else if (rx_dv)
                  state_next = gemac_rx_pkg::RX_ERROR;
            gemac_rx_pkg::RX_PREAMBLE:
               if (!rx_dv)
                  state_next = gemac_rx_pkg::RX_ERROR;
               else if (rxd == gemac_rx_pkg::SFD_BYTE)
                  state_next = gemac_rx_pkg::RX_FRAME;
               else if (rxd != gemac_rx_pkg::PREAMBLE_BYTE)
                  state_next = gemac_rx_pkg::RX_ERROR;
            gemac_rx_pkg::RX_FRAME:
               if (!rx_dv && crc_match)
                  state_next = gemac_rx_pkg::RX_GOODFRAME;
               else if (!rx_dv)
                  state_next = gemac_rx_pkg::RX_ERROR;
               else if (filt_done && is_pause)
                  state_next = gemac_rx_pkg::RX_PAUSE_SKIP;
               else if (filt_done && !keep)
                  state_next = gemac_rx_pkg::RX_DROP;       // not for this station.
            gemac_rx_pkg::RX_PAUSE_SKIP:                 // source address.
               if (!rx_dv)
                  state_next = gemac_rx_pkg::RX_DROP;
               else if (byte_idx == gemac_rx_pkg::TYPE_IDX - 11'd1)
                  state_next = gemac_rx_pkg::RX_PAUSE_CHK88;
            gemac_rx_pkg::RX_PAUSE_CHK88:
               if (!rx_dv || rxd != gemac_rx_pkg::PAUSE_TYPE_HI)
                  state_next = gemac_rx_pkg::RX_DROP;
               else
                  state_next = gemac_rx_pkg::RX_PAUSE_CHK08;
            gemac_rx_pkg::RX_PAUSE_CHK08:
               if (!rx_dv || rxd != gemac_rx_pkg::PAUSE_TYPE_LO)
                  state_next = gemac_rx_pkg::RX_DROP;
               else
                  state_next = gemac_rx_pkg::RX_PAUSE_CHK00;
            gemac_rx_pkg::RX_PAUSE_CHK00:
               if (!rx_dv || rxd != gemac_rx_pkg::PAUSE_OP_HI)
                  state_next = gemac_rx_pkg::RX_DROP;
               else
                  state_next = gemac_rx_pkg::RX_PAUSE_CHK01;
            gemac_rx_pkg::RX_PAUSE_CHK01:
               if (!rx_dv || rxd != gemac_rx_pkg::PAUSE_OP_LO)
                  state_next = gemac_rx_pkg::RX_DROP;
               else
                  state_next = gemac_rx_pkg::RX_PAUSE_STORE_MSB;
            gemac_rx_pkg::RX_PAUSE_STORE_MSB:
               state_next = rx_dv ? gemac_rx_pkg::RX_PAUSE_STORE_LSB : gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_PAUSE_STORE_LSB:
               state_next = rx_dv ? gemac_rx_pkg::RX_PAUSE_WAIT_CRC : gemac_rx_pkg::RX_DROP;
            gemac_rx_pkg::RX_PAUSE_WAIT_CRC:
               if (!rx_dv && long_enough && crc_match)
                  state_next = gemac_rx_pkg::RX_DO_PAUSE;
               else if (!rx_dv)
                  state_next = gemac_rx_pkg::RX_DROP;   // runt or bad crc.
            gemac_rx_pkg::RX_GOODFRAME,
            gemac_rx_pkg::RX_DO_PAUSE:
               state_next = gemac_rx_pkg::RX_IDLE;
            gemac_rx_pkg::RX_DROP,
            gemac_rx_pkg::RX_ERROR:
               if (!rx_dv)
                  state_next = gemac_rx_pkg::RX_IDLE;
            default:
               state_next = gemac_rx_pkg::RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         state        <= gemac_rx_pkg::RX_IDLE;
         rx_ack       <= 1'b0;
         pause_quanta <= '0;
         out_idx      <= '0;
      end
      else
      begin
         state  <= state_next;
         rx_ack <= (state == gemac_rx_pkg::RX_GOODFRAME);
         if (state_next == gemac_rx_pkg::RX_DO_PAUSE)
            pause_quanta <= quanta_hold;            // only a checked frame updates it.
         if (sfd_seen)
            out_idx <= '0;
         else if (filt_done && out_idx < byte_idx)
            out_idx <= out_idx + 1'b1;
      end
   end

   always_ff @(posedge rx_clk)
   begin
      if (state == gemac_rx_pkg::RX_PAUSE_STORE_MSB)
         quanta_hold[15:8] <= rxd;
      if (state == gemac_rx_pkg::RX_PAUSE_STORE_LSB)
         quanta_hold[7:0] <= rxd;
   end

   assign sfd_seen = (state == gemac_rx_pkg::RX_PREAMBLE) && rx_dv && !rx_er &&
                     (rxd == gemac_rx_pkg::SFD_BYTE);
   assign crc_clear = (state == gemac_rx_pkg::RX_IDLE) || sfd_seen;
   assign crc_calc = state inside {gemac_rx_pkg::RX_FRAME, gemac_rx_pkg::RX_PAUSE_SKIP,
                                   gemac_rx_pkg::RX_PAUSE_CHK88, gemac_rx_pkg::RX_PAUSE_CHK08,
                                   gemac_rx_pkg::RX_PAUSE_CHK00, gemac_rx_pkg::RX_PAUSE_CHK01,
                                   gemac_rx_pkg::RX_PAUSE_STORE_MSB,
                                   gemac_rx_pkg::RX_PAUSE_STORE_LSB,
                                   gemac_rx_pkg::RX_PAUSE_WAIT_CRC};

   assign keep = filt_done && ((pass_ucast && is_ucast) || (pass_mcast && is_mcast) ||
                               (pass_bcast && is_bcast) || (pass_pause && is_pause) || pass_all);

   // done shows up as dest byte 0 leaves the delay line, out_idx then walks the frame.
   assign rx_valid   = keep && (out_idx < byte_idx);
   assign rx_error   = (state == gemac_rx_pkg::RX_ERROR);
   assign pause_rcvd = (state == gemac_rx_pkg::RX_DO_PAUSE);

endmodule

/* logic/gemac_rx.sv */
`timescale 1ns/1ps

module gemac_rx
  #(
   parameter int DELAY_DEPTH   = 6,
   parameter int MIN_PAUSE_LEN = 64
  )
  (
   input  logic                    rx_clk,
   input  logic                    reset,
   input  logic                    gmii_rx_dv,
   input  logic                    gmii_rx_er,
   input  gemac_rx_pkg::byte_t     gmii_rxd,
   input  gemac_rx_pkg::mac_addr_t ucast_addr,
   input  gemac_rx_pkg::mac_addr_t mcast_addr,
   input  logic                    pass_ucast,
   input  logic                    pass_mcast,
   input  logic                    pass_bcast,
   input  logic                    pass_pause,
   input  logic                    pass_all,
   output gemac_rx_pkg::byte_t     rx_data,
   output logic                    rx_valid,
   output logic                    rx_error,
   output logic                    rx_ack,
   output gemac_rx_pkg::quanta_t   pause_quanta,
   output logic                    pause_rcvd
  );

   gemac_rx_pkg::byte_t     rxd_d1;
   logic                    rx_dv_d1;
   logic                    rx_er_d1;
   gemac_rx_pkg::byte_idx_t byte_idx;
   logic                    sfd_seen;
   logic                    crc_clear;
   logic                    crc_calc;
   logic                    crc_match;
   logic                    frame_byte;
   logic                    is_ucast;
   logic                    is_mcast;
   logic                    is_bcast;
   logic                    is_pause;
   logic                    done_ucast;
   logic                    done_mcast;
   logic                    done_bcast;
   logic                    done_pause;
   logic                    filt_done;

   always_ff @(posedge rx_clk)
   begin
      if (reset)
      begin
         rx_dv_d1 <= 1'b0;
         rx_er_d1 <= 1'b0;
      end
      else
      begin
         rx_dv_d1 <= gmii_rx_dv;
         rx_er_d1 <= gmii_rx_er;
      end
   end

   always_ff @(posedge rx_clk)
   begin
      rxd_d1 <= gmii_rxd;
   end

   assign frame_byte = crc_calc && rx_dv_d1;    // a byte after the sfd.
   assign filt_done  = done_ucast && done_mcast && done_bcast && done_pause;

   rx_delay_line #(.DELAY_DEPTH(DELAY_DEPTH)) u_delay (
      .rx_clk(rx_clk), .reset(reset),
      .din_data(rxd_d1), .din_dv(rx_dv_d1), .din_er(rx_er_d1),
      .dout_data(rx_data), .dout_dv(), .dout_er());

   rx_byte_counter u_counter (
      .rx_clk(rx_clk), .reset(reset), .clear(sfd_seen), .count_en(frame_byte),
      .byte_idx(byte_idx));

   address_filter u_af_ucast (
      .rx_clk(rx_clk), .reset(reset), .start(sfd_seen), .data(rxd_d1), .byte_idx(byte_idx),
      .address(ucast_addr), .match(is_ucast), .done(done_ucast));
   address_filter u_af_mcast (
      .rx_clk(rx_clk), .reset(reset), .start(sfd_seen), .data(rxd_d1), .byte_idx(byte_idx),
      .address(mcast_addr), .match(is_mcast), .done(done_mcast));
   address_filter u_af_bcast (
      .rx_clk(rx_clk), .reset(reset), .start(sfd_seen), .data(rxd_d1), .byte_idx(byte_idx),
      .address(gemac_rx_pkg::BCAST_ADDR), .match(is_bcast), .done(done_bcast));
   address_filter u_af_pause (
      .rx_clk(rx_clk), .reset(reset), .start(sfd_seen), .data(rxd_d1), .byte_idx(byte_idx),
      .address(gemac_rx_pkg::PAUSE_ADDR), .match(is_pause), .done(done_pause));

   crc32_check u_crc (
      .rx_clk(rx_clk), .reset(reset), .clear(crc_clear), .calc(frame_byte), .data(rxd_d1),
      .crc_match(crc_match));

   rx_frame_fsm #(.MIN_PAUSE_LEN(MIN_PAUSE_LEN)) u_fsm (
      .rx_clk(rx_clk), .reset(reset), .rxd(rxd_d1), .rx_dv(rx_dv_d1), .rx_er(rx_er_d1),
      .byte_idx(byte_idx), .is_ucast(is_ucast), .is_mcast(is_mcast), .is_bcast(is_bcast),
      .is_pause(is_pause), .filt_done(filt_done), .pass_ucast(pass_ucast),
      .pass_mcast(pass_mcast), .pass_bcast(pass_bcast), .pass_pause(pass_pause),
      .pass_all(pass_all), .crc_match(crc_match), .sfd_seen(sfd_seen), .crc_clear(crc_clear),
      .crc_calc(crc_calc), .rx_valid(rx_valid), .rx_ack(rx_ack), .rx_error(rx_error),
      .pause_quanta(pause_quanta), .pause_rcvd(pause_rcvd));

endmodule

/* verif/gemac_rx_checker.sv */
`timescale 1ns/1ps

module gemac_rx_checker
  (
   input  logic                  rx_clk,
   input  logic                  reset,
   input  gemac_rx_pkg::byte_t   rx_data,
   input  logic                  rx_valid,
   input  logic                  rx_error,
   input  logic                  rx_ack,
   input  gemac_rx_pkg::quanta_t pause_quanta,
   input  logic                  pause_rcvd,
   input  logic                  frame_end,
   output int                    errors,
   output int                    frames_checked
  );

   bit                    exp_ack_q [$];
   bit                    exp_err_q [$];
   bit                    exp_pause_q [$];
   gemac_rx_pkg::quanta_t exp_quanta_q [$];
   int                    exp_len_q [$];       // -1 means the bytes are not checked.
   gemac_rx_pkg::byte_t   exp_bytes_q [$];
   gemac_rx_pkg::byte_t   got_q [$];
   int                    ack_n;
   int                    err_n;
   int                    pause_n;
   logic                  err_prev;

   task automatic push_expected(input bit ack, input bit err, input bit pause,
                                input gemac_rx_pkg::quanta_t quanta, input int len);
      exp_ack_q.push_back(ack);
      exp_err_q.push_back(err);
      exp_pause_q.push_back(pause);
      exp_quanta_q.push_back(quanta);
      exp_len_q.push_back(len);
   endtask

   task automatic push_byte(input gemac_rx_pkg::byte_t b);
      exp_bytes_q.push_back(b);
   endtask

   task automatic check_value(input string name, input int got, input int exp);
      if (got != exp)
      begin
         $display("[FAIL] frame %0d %s: got %h expected %h", frames_checked, name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_frame();
      int                  len;
      gemac_rx_pkg::byte_t b;
      if (exp_len_q.size() == 0)
      begin
         $display("frame %0d ended with no expected result queued", frames_checked);
         errors++;
         return;
      end
      len = exp_len_q.pop_front();
      check_value("rx_ack pulses", ack_n, exp_ack_q.pop_front());
      check_value("rx_error events", err_n, exp_err_q.pop_front());
      check_value("pause_rcvd pulses", pause_n, exp_pause_q.pop_front());
      check_value("pause_quanta", pause_quanta, exp_quanta_q.pop_front());
      if (len >= 0)
      begin
         check_value("rx_valid byte count", got_q.size(), len);
         for (int i = 0; i < len; i++)
         begin
            b = exp_bytes_q.pop_front();
            if (i < got_q.size())
               check_value($sformatf("rx_data[%0d]", i), got_q[i], b);
         end
      end
      frames_checked++;
   endtask

   // outputs settle after the rising edge, so look at them in the low phase.
   always @(negedge rx_clk)
   begin
      if (reset)
      begin
         ack_n = 0;
         err_n = 0;
         pause_n = 0;
         err_prev = 1'b0;
         got_q.delete();
      end
      else
      begin
         if (rx_valid)
            got_q.push_back(rx_data);
         if (rx_ack)
            ack_n++;
         if (rx_error && !err_prev)
            err_n++;
         if (pause_rcvd)
            pause_n++;
         err_prev = rx_error;
         if (frame_end)
         begin
            compare_frame();
            ack_n = 0;
            err_n = 0;
            pause_n = 0;
            got_q.delete();
         end
      end
   end

   initial
   begin
      errors = 0;
      frames_checked = 0;
   end

endmodule

/* verif/gemac_rx_properties.sv */
`timescale 1ns/1ps

module gemac_rx_properties
  (
   input logic rx_clk,
   input logic reset,
   input logic rx_ack,
   input logic rx_error,
   input logic pause_rcvd,
   input logic rx_valid
  );

   ack_one_cycle: assert property (@(posedge rx_clk) disable iff (reset)
      rx_ack |=> !rx_ack)
      else $error("rx_ack held for more than one cycle");

   ack_error_apart: assert property (@(posedge rx_clk) disable iff (reset)
      !(rx_ack && rx_error))
      else $error("rx_ack and rx_error high together");

   pause_one_cycle: assert property (@(posedge rx_clk) disable iff (reset)
      pause_rcvd |=> !pause_rcvd)
      else $error("pause_rcvd held for more than one cycle");

   valid_low_after_reset: assert property (@(posedge rx_clk)
      reset |=> !rx_valid)
      else $error("rx_valid high right after reset");

endmodule

bind rx_frame_fsm gemac_rx_properties u_properties (
   .rx_clk(rx_clk), .reset(reset), .rx_ack(rx_ack), .rx_error(rx_error),
   .pause_rcvd(pause_rcvd), .rx_valid(rx_valid));

/* verif/gemac_rx_tb.sv */
`timescale 1ns/1ps

module gemac_rx_tb;

   localparam gemac_rx_pkg::mac_addr_t UCAST   = 48'h0211_2233_4455;
   localparam gemac_rx_pkg::mac_addr_t MCAST   = 48'h0100_5E00_0007;
   localparam gemac_rx_pkg::mac_addr_t FOREIGN = 48'h0266_7788_99AA;
   localparam gemac_rx_pkg::mac_addr_t BCAST   = 48'hFFFF_FFFF_FFFF;
   localparam gemac_rx_pkg::mac_addr_t PAUSE   = 48'h0180_C200_0001;
   localparam gemac_rx_pkg::mac_addr_t SOURCE  = 48'h02AA_BBCC_DDEE;
   localparam int NUM_FRAMES   = 15;
   localparam int MAX_WIRE_LEN = 86;                // preamble, sfd, header, 60 payload, fcs.
   localparam int CYCLE_LIMIT  = 16 + NUM_FRAMES * (MAX_WIRE_LEN + 44) + 200;

   logic                  rx_clk;
   logic                  reset;
   logic                  gmii_rx_dv;
   logic                  gmii_rx_er;
   gemac_rx_pkg::byte_t   gmii_rxd;
   logic                  pass_ucast;
   logic                  pass_mcast;
   logic                  pass_bcast;
   logic                  pass_pause;
   logic                  pass_all;
   gemac_rx_pkg::byte_t   rx_data;
   logic                  rx_valid;
   logic                  rx_error;
   logic                  rx_ack;
   gemac_rx_pkg::quanta_t pause_quanta;
   logic                  pause_rcvd;
   logic                  frame_end;
   int                    errors;
   int                    frames_checked;
   int                    cycle_count;
   gemac_rx_pkg::byte_t   frame_q [$];             // bytes after the sfd.
   gemac_rx_pkg::quanta_t exp_quanta;

   gemac_rx #(.DELAY_DEPTH(6), .MIN_PAUSE_LEN(64)) u_gemac_rx (
      .rx_clk(rx_clk), .reset(reset), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
      .gmii_rxd(gmii_rxd), .ucast_addr(UCAST), .mcast_addr(MCAST), .pass_ucast(pass_ucast),
      .pass_mcast(pass_mcast), .pass_bcast(pass_bcast), .pass_pause(pass_pause),
      .pass_all(pass_all), .rx_data(rx_data), .rx_valid(rx_valid), .rx_error(rx_error),
      .rx_ack(rx_ack), .pause_quanta(pause_quanta), .pause_rcvd(pause_rcvd));

   gemac_rx_checker u_checker (
      .rx_clk(rx_clk), .reset(reset), .rx_data(rx_data), .rx_valid(rx_valid),
      .rx_error(rx_error), .rx_ack(rx_ack), .pause_quanta(pause_quanta),
      .pause_rcvd(pause_rcvd), .frame_end(frame_end), .errors(errors),
      .frames_checked(frames_checked));

   // reflected form, poly edb88320, result already inverted.
   function automatic logic [31:0] crc32_ref(input int n);
      logic [31:0] crc;
      crc = 32'hFFFF_FFFF;
      for (int i = 0; i < n; i++)
      begin
         crc ^= {24'h0, frame_q[i]};
         for (int k = 0; k < 8; k++)
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
      end
      return ~crc;
   endfunction

   // a frame that fails the filter is dropped quietly, mac control aside.
   function automatic void expected_frame(input bit bad_pre, input bit er_mid,
                                          output bit ack, output bit err, output bit pause,
                                          output int len, inout gemac_rx_pkg::quanta_t quanta);
      gemac_rx_pkg::mac_addr_t dest;
      logic [31:0]             fcs;
      int                      n;
      bit                      crc_ok;
      bit                      keep;
      n = frame_q.size();
      dest = {frame_q[0], frame_q[1], frame_q[2], frame_q[3], frame_q[4], frame_q[5]};
      fcs = {frame_q[n-1], frame_q[n-2], frame_q[n-3], frame_q[n-4]};
      crc_ok = (crc32_ref(n - 4) == fcs);
      keep = pass_all || (pass_ucast && dest == UCAST) || (pass_mcast && dest == MCAST) ||
             (pass_bcast && dest == BCAST) || (pass_pause && dest == PAUSE);
      ack = 1'b0;
      err = 1'b0;
      pause = 1'b0;
      len = keep ? n : 0;
      if (bad_pre || er_mid)
      begin
         err = 1'b1;
         len = -1;
      end
      else if (dest == PAUSE)
      begin
         if (keep)
            len = -1;
         if (crc_ok && n >= 64 && frame_q[12] == 8'h88 && frame_q[13] == 8'h08 &&
             frame_q[14] == 8'h00 && frame_q[15] == 8'h01)
         begin
            pause = 1'b1;
            quanta = {frame_q[16], frame_q[17]};
         end
      end
      else if (keep)
      begin
         if (crc_ok)
            ack = 1'b1;
         else
            err = 1'b1;
      end
   endfunction

   task automatic start_frame(input gemac_rx_pkg::mac_addr_t dest, input logic [15:0] etype);
      frame_q.delete();
      for (int i = 5; i >= 0; i--)
         frame_q.push_back(dest[i*8 +: 8]);
      for (int i = 5; i >= 0; i--)
         frame_q.push_back(SOURCE[i*8 +: 8]);
      frame_q.push_back(etype[15:8]);
      frame_q.push_back(etype[7:0]);
   endtask

   task automatic add_random(input int n);
      for (int i = 0; i < n; i++)
         frame_q.push_back(8'($urandom));
   endtask

   task automatic add_fcs();
      logic [31:0] crc;
      crc = crc32_ref(frame_q.size());
      for (int i = 0; i < 4; i++)
         frame_q.push_back(crc[i*8 +: 8]);     // lsb first.
   endtask

   task automatic corrupt_fcs();
      frame_q[frame_q.size()-3] ^= 8'h5A;
   endtask

   task automatic build_pause(input logic [15:0] opcode, input logic [15:0] quanta);
      start_frame(PAUSE, 16'h8808);
      frame_q.push_back(opcode[15:8]);
      frame_q.push_back(opcode[7:0]);
      frame_q.push_back(quanta[15:8]);
      frame_q.push_back(quanta[7:0]);
      add_random(42);                          // pads to 64 bytes with the fcs.
   endtask

   task automatic set_filter(input bit u, input bit m, input bit b, input bit p, input bit a);
      @(posedge rx_clk);
      pass_ucast <= u;
      pass_mcast <= m;
      pass_bcast <= b;
      pass_pause <= p;
      pass_all <= a;
      @(posedge rx_clk);
   endtask

   task automatic send_frame(input bit bad_pre, input int er_at);
      bit ack;
      bit err;
      bit pause;
      int len;
      expected_frame(bad_pre, er_at >= 0, ack, err, pause, len, exp_quanta);
      u_checker.push_expected(ack, err, pause, exp_quanta, len);
      for (int i = 0; i < len; i++)
         u_checker.push_byte(frame_q[i]);
      for (int i = 0; i < 8; i++)
      begin
         @(posedge rx_clk);
         gmii_rx_dv <= 1'b1;
         gmii_rx_er <= 1'b0;
         gmii_rxd <= (i == 7) ? 8'hD5 : ((bad_pre && i == 3) ? 8'h54 : 8'h55);
      end
      foreach (frame_q[i])
      begin
         @(posedge rx_clk);
         gmii_rxd <= frame_q[i];
         gmii_rx_er <= (i == er_at);
      end
      @(posedge rx_clk);
      gmii_rx_dv <= 1'b0;
      gmii_rx_er <= 1'b0;
      gmii_rxd <= 8'h00;
      repeat (40) @(posedge rx_clk);
      frame_end <= 1'b1;
      @(posedge rx_clk);
      frame_end <= 1'b0;
   endtask

   initial
   begin
      rx_clk = 1'b0;
      forever #2 rx_clk = ~rx_clk;
   end

   always @(posedge rx_clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Some tests failed");
         $finish;
      end
   end

   initial
   begin
      void'($urandom(23));
      reset = 1'b1;
      gmii_rx_dv = 1'b0;
      gmii_rx_er = 1'b0;
      gmii_rxd = 8'h00;
      pass_ucast = 1'b0;
      pass_mcast = 1'b0;
      pass_bcast = 1'b0;
      pass_pause = 1'b0;
      pass_all = 1'b0;
      frame_end = 1'b0;
      cycle_count = 0;
      exp_quanta = '0;
      repeat (16) @(posedge rx_clk);
      reset <= 1'b0;
      set_filter(1, 0, 0, 0, 0);
      repeat (3)
      begin
         start_frame(UCAST, 16'h0800);
         add_random(46 + $urandom % 15);
         add_fcs();
         send_frame(0, -1);
      end
      start_frame(FOREIGN, 16'h0800);
      add_random(50);
      add_fcs();
      send_frame(0, -1);
      set_filter(1, 0, 0, 0, 1);
      send_frame(0, -1);                        // same frame, now passed by pass_all.
      start_frame(BCAST, 16'h0806);
      add_random(46);
      add_fcs();
      set_filter(1, 0, 0, 0, 0);
      send_frame(0, -1);
      set_filter(1, 0, 1, 0, 0);
      send_frame(0, -1);
      start_frame(MCAST, 16'h0800);
      add_random(48);
      add_fcs();
      set_filter(1, 1, 0, 0, 0);
      send_frame(0, -1);
      set_filter(1, 0, 0, 0, 0);
      start_frame(UCAST, 16'h0800);
      add_random(52);
      add_fcs();
      corrupt_fcs();
      send_frame(0, -1);
      start_frame(UCAST, 16'h0800);
      add_random(52);
      add_fcs();
      send_frame(0, 20);                        // gmii_rx_er in the payload.
      send_frame(1, -1);
      repeat (2)
      begin
         build_pause(16'h0001, 16'($urandom));
         add_fcs();
         send_frame(0, -1);
      end
      build_pause(16'h0002, 16'($urandom));
      add_fcs();
      send_frame(0, -1);
      build_pause(16'h0001, 16'($urandom));
      add_fcs();
      corrupt_fcs();
      send_frame(0, -1);
      repeat (10) @(posedge rx_clk);
      $display("checks failed: %0d, frames checked: %0d of %0d", errors, frames_checked,
               NUM_FRAMES);
      if (errors == 0 && frames_checked == NUM_FRAMES)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

/* compile.f */
logic/gemac_rx_pkg.sv
logic/rx_delay_line.sv
logic/rx_byte_counter.sv
logic/address_filter.sv
logic/crc32_check.sv
logic/rx_frame_fsm.sv
logic/gemac_rx.sv
verif/gemac_rx_checker.sv
verif/gemac_rx_properties.sv
verif/gemac_rx_tb.sv

/* Makefile */
VERILATOR  = verilator
TOP        = gemac_rx_tb
RTL_TOP    = gemac_rx
FILELIST   = compile.f
FLAGS      = --binary --timing --assert --Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing
PASS_MSG   = All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
